/* src/video_pkg.sv */
//////////////////////////////
// Raster timing and pixel types shared by the video blocks
// and the testbench
//////////////////////////////

package video_pkg;

  // Raster size, measured on hardware
  localparam logic [8:0] num_rows = 9'd263;
  localparam logic [8:0] num_cols = 9'd260;

  // Render window, 208 x 232
  localparam logic [8:0] first_row_render = 9'd16;
  localparam logic [8:0] last_row_render  = 9'd247;
  localparam logic [8:0] first_col_render = 9'd23;
  localparam logic [8:0] last_col_render  = 9'd230;

  localparam logic [8:0] first_row_vsync = 9'd257;
  localparam logic [8:0] last_row_vsync  = 9'd259;
  localparam logic [8:0] first_col_hsync = 9'd240;
  localparam logic [8:0] last_col_hsync  = 9'd259;

  typedef logic [3:0] color_idx_t;

  localparam color_idx_t color_black = 4'd1;

  typedef struct packed {
    logic [8:0] row;
    logic [8:0] col;
  } raster_pos_t;

  typedef struct packed {
    logic vbl;
    logic de;
    logic hs;
    logic vs;
  } sync_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

endpackage

/* src/bus_pkg.sv */
//////////////////////////////
// CPU address map, control register layout and
// memory write records
//////////////////////////////

package bus_pkg;

  localparam int cpu_addr_width = 13;

  // Decoded from A[12:9]
  typedef enum logic [2:0] {
    region_vram, // $0000-$0FFF
    region_bgm,  // $1000-$11FF
    region_oam,  // $1200-$13FF
    region_reg,  // $1400-$15FF
    region_apu,  // $1600-$17FF
    region_none
  } bus_region_t;

  // Register 0 sits in the high byte
  typedef struct packed {
    logic       bm_inv_y;  // Invert YMAX effect
    logic       bm_inv_x;  // Invert XMAX effect
    logic       sp_2clr;
    logic       sp_ena;
    logic       boc_dis;
    logic       sp_hide7;
    logic       bm_lores;  // 1 selects low resolution
    logic       bm_ena;
    logic [3:0] bm_clr_fg; // High resolution only
    logic [3:0] bm_clr_bg;
    logic [3:0] bm_ymax;
    logic [3:0] bm_xmax;
    logic [3:0] ch_clr_fg;
    logic [3:0] ch_clr_bg;
  } ctrl_regs_t;

  typedef struct packed {
    logic [6:0] addr;
    logic [3:0] be;
    logic [7:0] data;
  } bgm_write_t;

  typedef struct packed {
    logic [9:0] addr;
    logic [7:0] data;
    logic       valid;
  } rom_init_t;

endpackage

/* src/video_timing.sv */
//////////////////////////////
// Raster counter and sync generator, also times the
// shadow register copy
//////////////////////////////

`timescale 1ns/100ps

module video_timing
  import video_pkg::*;
(
  input  logic        CLK,
  input  logic        reset,
  input  logic        ce,
  output raster_pos_t pos,
  output sync_t       sync,
  output logic        render_px,
  output logic        reg_copy
);

  raster_pos_t pos_next;
  logic        render_row;
  logic        render_col;

  //////////////////////////////
  // Row / column counter

  always_comb begin
    pos_next = pos;
    if (pos.col == num_cols - 9'd1) begin
      pos_next.col = '0;
      if (pos.row == num_rows - 9'd1)
        pos_next.row = '0;
      else
        pos_next.row = pos.row + 9'd1;
    end else begin
      pos_next.col = pos.col + 9'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset)
      pos <= '0;
    else if (ce)
      pos <= pos_next;
  end

  //////////////////////////////
  // Window flags and sync

  assign render_row = (pos.row >= first_row_render) && (pos.row <= last_row_render);
  assign render_col = (pos.col >= first_col_render) && (pos.col <= last_col_render);
  assign render_px  = render_row && render_col;

  // Start of vertical sync
  assign reg_copy = ce && (pos.row == first_row_vsync) && (pos.col == '0);

  always_ff @(posedge CLK) begin
    if (reset) begin
      sync <= '0;
    end else if (ce) begin
      sync.de  <= render_px;
      sync.vbl <= !render_row;
      sync.hs  <= (pos.col >= first_col_hsync) && (pos.col <= last_col_hsync);
      sync.vs  <= (pos.row >= first_row_vsync) && (pos.row <= last_row_vsync);
    end
  end

  col_in_range: assert property (@(posedge CLK) disable iff (reset)
    pos.col < num_cols);

endmodule

/* src/cpu_port.sv */
//////////////////////////////
// CPU write decoder for control registers and BGM
//////////////////////////////

`timescale 1ns/100ps

module cpu_port
  import bus_pkg::*;
(
  input  logic                      CLK,
  input  logic                      reset,
  input  logic [cpu_addr_width-1:0] addr,
  input  logic [7:0]                data,
  input  logic                      wr_n,
  input  logic                      cs_n,
  input  logic                      reg_copy,
  output ctrl_regs_t                regs,
  output bgm_write_t                bgm_wr
);

  bus_region_t     region;
  logic            cpu_wr;
  logic            reg_wr;
  logic            bgm_sel;
  logic [3:0][7:0] shadow; // [3] is register 0

  //////////////////////////////
  // Address decode

  always_comb begin
    if (!addr[cpu_addr_width-1]) begin
      region = region_vram;
    end else begin
      case (addr[11:9])
        3'd0:    region = region_bgm;
        3'd1:    region = region_oam;
        3'd2:    region = region_reg;
        3'd3:    region = region_apu;
        default: region = region_none;
      endcase
    end
  end

  assign cpu_wr  = !cs_n && !wr_n;
  assign reg_wr  = cpu_wr && (region == region_reg);
  assign bgm_sel = cpu_wr && (region == region_bgm);

  //////////////////////////////
  // Control registers

  always_ff @(posedge CLK) begin
    if (reset)
      shadow <= '0;
    else if (reg_wr)
      shadow[2'd3 - addr[1:0]] <= data;
  end

  // Active copy taken once per frame
  always_ff @(posedge CLK) begin
    if (reset)
      regs <= '0;
    else if (reg_copy)
      regs <= ctrl_regs_t'(shadow);
  end

  // BGM byte lane write
  assign bgm_wr.addr = addr[8:2];
  assign bgm_wr.be   = {3'b000, bgm_sel} << addr[1:0];
  assign bgm_wr.data = data;

  one_target: assert property (@(posedge CLK) disable iff (reset)
    !(reg_wr && (bgm_wr.be != 4'b0000)));

endmodule

/* src/bgm_ram.sv */
//////////////////////////////
// Background memory, 128 words of 4 bytes
//////////////////////////////

`timescale 1ns/100ps

module bgm_ram
  import bus_pkg::*;
(
  input  logic        CLK,
  input  bgm_write_t  wr,
  input  logic [6:0]  rd_addr,
  output logic [31:0] rd_data
);

  logic [3:0][7:0] mem [128];

  // CPU side, byte lanes
  always_ff @(posedge CLK) begin
    for (int i = 0; i < 4; i++) begin
      if (wr.be[i])
        mem[wr.addr][i] <= wr.data;
    end
  end

  // Renderer side
  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* src/bg_render.sv */
//////////////////////////////
// Background pipeline, character / bitmap tiles
// into a per-pixel colour index
//////////////////////////////

`timescale 1ns/100ps

module bg_render
  import video_pkg::*;
  import bus_pkg::*;
(
  input  logic        CLK,
  input  logic        reset,
  input  logic        ce,
  input  raster_pos_t pos,
  input  ctrl_regs_t  regs,
  input  rom_init_t   rom_init,
  output logic [6:0]  bgm_addr,
  input  logic [31:0] bgm_data,
  output color_idx_t  color
);

  logic [7:0] chr [1024]; // Character pattern ROM
  logic [9:0] chr_addr;
  logic [7:0] chr_data;

  logic [4:0] tx, ty;
  logic       tile_load;
  logic       xwin, ywin;
  logic       is_ch, is_bm;
  logic [7:0] bgm_byte;

  logic [7:0] ch_pat;
  logic [2:0] hi_sel, lo_sel;
  logic [1:0] hi_pat;
  logic [3:0] lo_pat;
  logic [7:0] bm_pat;
  color_idx_t bm_fgc;
  logic [7:0] pat;

  color_idx_t fgc, bgc;
  logic [7:0] shift;

  //////////////////////////////
  // Tile and window split

  assign tx        = pos.col[7:3];
  assign ty        = pos.row[7:3];
  assign tile_load = (pos.col[2:0] == 3'd4);

  assign xwin  = (tx[4:1] < regs.bm_xmax) ^ regs.bm_inv_x;
  assign ywin  = (ty[4:1] < regs.bm_ymax) ^ regs.bm_inv_y;
  assign is_ch = xwin && ywin;
  assign is_bm = regs.bm_ena && !is_ch;

  assign bgm_addr = {ty[4:1], tx[4:2]};
  assign bgm_byte = bgm_data[{tx[1:0], 3'b000} +: 8];

  // ROM load and pattern fetch
  always_ff @(posedge CLK) begin
    if (rom_init.valid)
      chr[rom_init.addr] <= rom_init.data;
  end

  assign chr_addr = {bgm_byte[6:0], pos.row[2:0]};

  always_ff @(posedge CLK) begin
    chr_data <= chr[chr_addr];
  end

  assign ch_pat = ty[0] ? 8'h00 : {2'b00, chr_data[7:2]}; // Odd tile rows blank

  //////////////////////////////
  // Bitmap decode

  assign hi_sel = {~pos.row[3:2], 1'b0};
  assign lo_sel = {~pos.row[3], 2'b00};
  assign hi_pat = bgm_byte[hi_sel +: 2];
  assign lo_pat = bgm_byte[lo_sel +: 4];

  always_comb begin
    bm_pat = 8'h00;
    bm_fgc = regs.bm_clr_fg;
    if (is_bm) begin
      if (regs.bm_lores) begin
        if (lo_pat != 4'd0) begin // Zero shows the background colour
          bm_pat = 8'hff;
          bm_fgc = lo_pat;
        end
      end else begin
        bm_pat = {{4{hi_pat[1]}}, {4{hi_pat[0]}}};
      end
    end
  end

  // Patterns shift out LSB first, so reverse
  always_comb begin
    for (int i = 0; i < 8; i++)
      pat[7 - i] = is_ch ? ch_pat[i] : bm_pat[i];
  end

  //////////////////////////////
  // Pixel shifter

  always_ff @(posedge CLK) begin
    if (ce && tile_load) begin
      fgc <= is_ch ? regs.ch_clr_fg : bm_fgc;
      bgc <= is_ch ? regs.ch_clr_bg : regs.bm_clr_bg;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset)
      shift <= '0;
    else if (ce)
      shift <= tile_load ? pat : {1'b0, shift[7:1]};
  end

  assign color = shift[0] ? fgc : bgc;

  rom_load_idle: assert property (@(posedge CLK) disable iff (reset)
    rom_init.valid |-> !ce);

endmodule

/* src/color_gen.sv */
//////////////////////////////
// Colour index to RGB, black outside the window
//////////////////////////////

`timescale 1ns/100ps

module color_gen
  import video_pkg::*;
(
  input  logic       CLK,
  input  logic       ce,
  input  logic       render_px,
  input  color_idx_t color,
  output rgb_t       rgb
);

  logic       render_q; // Lines up with DE
  color_idx_t pd;

  always_ff @(posedge CLK) begin
    if (ce)
      render_q <= render_px;
  end

  assign pd = render_q ? color : color_black;

  // RGB connector levels
  always_comb begin
    rgb = '0;
    case (pd)
      4'd0:  rgb = '{8'd0,   8'd0,   8'd160};
      4'd1:  rgb = '{8'd0,   8'd0,   8'd0};
      4'd2:  rgb = '{8'd0,   8'd0,   8'd245};
      4'd3:  rgb = '{8'd160, 8'd0,   8'd235};
      4'd4:  rgb = '{8'd0,   8'd245, 8'd0};
      4'd5:  rgb = '{8'd150, 8'd235, 8'd150};
      4'd6:  rgb = '{8'd0,   8'd235, 8'd235};
      4'd7:  rgb = '{8'd0,   8'd160, 8'd0};
      4'd8:  rgb = '{8'd245, 8'd0,   8'd0};
      4'd9:  rgb = '{8'd235, 8'd160, 8'd0};
      4'd10: rgb = '{8'd235, 8'd0,   8'd235};
      4'd11: rgb = '{8'd235, 8'd150, 8'd150};
      4'd12: rgb = '{8'd235, 8'd235, 8'd0};
      4'd13: rgb = '{8'd160, 8'd160, 8'd0};
      4'd14: rgb = '{8'd150, 8'd150, 8'd150};
      4'd15: rgb = '{8'd225, 8'd225, 8'd225};
    endcase
  end

endmodule

/* src/vdc_top.sv */
//////////////////////////////
// Background video display controller top level
//////////////////////////////

`timescale 1ns/100ps

module vdc_top
  import video_pkg::*;
  import bus_pkg::*;
(
  input  logic                      CLK,
  input  logic                      reset,
  input  logic                      CE,    // Pixel enable
  input  logic [cpu_addr_width-1:0] A,
  input  logic [7:0]                DB_I,
  input  logic                      WRB,   // Active low
  input  logic                      CSB,   // Active low
  input  rom_init_t                 rom_init,
  output sync_t                     sync,
  output rgb_t                      RGB
);

  raster_pos_t pos;
  logic        render_px;
  logic        reg_copy;
  ctrl_regs_t  regs;
  bgm_write_t  bgm_wr;
  logic [6:0]  bgm_addr;
  logic [31:0] bgm_data;
  color_idx_t  color;

  video_timing timing (
    .CLK(CLK), .reset(reset), .ce(CE),
    .pos(pos), .sync(sync), .render_px(render_px), .reg_copy(reg_copy)
  );

  cpu_port cpu (
    .CLK(CLK), .reset(reset), .addr(A), .data(DB_I), .wr_n(WRB), .cs_n(CSB),
    .reg_copy(reg_copy), .regs(regs), .bgm_wr(bgm_wr)
  );

  bgm_ram bgm (
    .CLK(CLK), .wr(bgm_wr), .rd_addr(bgm_addr), .rd_data(bgm_data)
  );

  bg_render render (
    .CLK(CLK), .reset(reset), .ce(CE), .pos(pos), .regs(regs),
    .rom_init(rom_init), .bgm_addr(bgm_addr), .bgm_data(bgm_data), .color(color)
  );

  color_gen colors (
    .CLK(CLK), .ce(CE), .render_px(render_px), .color(color), .rgb(RGB)
  );

endmodule

/* testbench/tb_vdc.sv */
//////////////////////////////
// Testbench for the background VDC, scans whole frames
// and checks every pixel colour and the sync counts
//////////////////////////////

`timescale 1ns/100ps

module tb_vdc
  import video_pkg::*;
  import bus_pkg::*;
();

  localparam int frame_cycles = int'(num_rows) * int'(num_cols);
  localparam int test_frames  = 11; // First VS wait plus all scanned and settling frames
  localparam int timeout_cycles = (test_frames + 1) * frame_cycles + 8192;

  logic                      CLK;
  logic                      reset;
  logic                      CE;
  logic [cpu_addr_width-1:0] A;
  logic [7:0]                DB_I;
  logic                      WRB;
  logic                      CSB;
  rom_init_t                 rom_init;
  sync_t                     sync;
  rgb_t                      RGB;

  integer      seed;
  int          cycles = 0;
  int          errors;         // Current test only
  int          passed;
  int          failed;
  logic        scanning;
  logic [15:0] allowed;        // Colour indices accepted inside DE
  logic [15:0] seen;
  sync_t       sync_q;
  int          frame_clk, de_clk, de_lines, hs_clk, hs_lines, vs_clk, vbl_clk;

  vdc_top DUT (
    .CLK(CLK), .reset(reset), .CE(CE), .A(A), .DB_I(DB_I), .WRB(WRB), .CSB(CSB),
    .rom_init(rom_init), .sync(sync), .RGB(RGB)
  );

  always #50 CLK = ~CLK;

  // Console palette
  function automatic rgb_t ref_rgb(input color_idx_t idx);
    rgb_t c;
    c = '0;
    case (idx)
      4'd0:  c = '{8'd0,   8'd0,   8'd160};
      4'd1:  c = '{8'd0,   8'd0,   8'd0};
      4'd2:  c = '{8'd0,   8'd0,   8'd245};
      4'd3:  c = '{8'd160, 8'd0,   8'd235};
      4'd4:  c = '{8'd0,   8'd245, 8'd0};
      4'd5:  c = '{8'd150, 8'd235, 8'd150};
      4'd6:  c = '{8'd0,   8'd235, 8'd235};
      4'd7:  c = '{8'd0,   8'd160, 8'd0};
      4'd8:  c = '{8'd245, 8'd0,   8'd0};
      4'd9:  c = '{8'd235, 8'd160, 8'd0};
      4'd10: c = '{8'd235, 8'd0,   8'd235};
      4'd11: c = '{8'd235, 8'd150, 8'd150};
      4'd12: c = '{8'd235, 8'd235, 8'd0};
      4'd13: c = '{8'd160, 8'd160, 8'd0};
      4'd14: c = '{8'd150, 8'd150, 8'd150};
      4'd15: c = '{8'd225, 8'd225, 8'd225};
    endcase
    return c;
  endfunction

  task automatic check_rgb(input rgb_t got, input logic [15:0] mask);
    logic ok;
    ok = 1'b0;
    for (int i = 0; i < 16; i++) begin
      if (got == ref_rgb(color_idx_t'(i))) begin
        seen[i] = 1'b1;
        ok = ok | mask[i];
      end
    end
    if (!ok) begin
      if (errors < 5)
        $display("Fail at %0t ns: RGB %h outside colour set %h", $time, got, mask);
      errors++;
    end
  endtask

  task automatic check_sync(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("Fail at %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////
  // Frame scanner, falling edge so DUT outputs are settled

  always @(negedge CLK) begin
    if (scanning) begin
      frame_clk++;
      check_rgb(RGB, sync.de ? allowed : (16'd1 << color_black)); // Black outside DE
      if (sync.de)
        de_clk++;
      if (sync.de && !sync_q.de)
        de_lines++;
      if (sync.hs)
        hs_clk++;
      if (sync.hs && !sync_q.hs)
        hs_lines++;
      if (sync.vs)
        vs_clk++;
      if (sync.vbl)
        vbl_clk++;
    end
    sync_q = sync;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // Bus and load tasks

  task automatic cpu_write(input logic [12:0] addr, input logic [7:0] data);
    @(posedge CLK);
    A    <= addr;
    DB_I <= data;
    CSB  <= 1'b0;
    WRB  <= 1'b0;
  endtask

  task automatic bus_idle();
    @(posedge CLK);
    CSB <= 1'b1;
    WRB <= 1'b1;
  endtask

  task automatic write_regs(input ctrl_regs_t value);
    logic [31:0] v;
    v = value;
    for (int r = 0; r < 4; r++)
      cpu_write(13'h1400 + 13'(r), v[31 - 8 * r -: 8]); // Register 0 is the high byte
    bus_idle();
  endtask

  task automatic fill_bgm(input logic rnd, input logic [7:0] value);
    logic [31:0] r;
    for (int i = 0; i < 512; i++) begin
      r = $random(seed);
      cpu_write(13'h1000 + 13'(i), rnd ? r[7:0] : value);
    end
    bus_idle();
  endtask

  task automatic load_rom(input logic rnd);
    logic [31:0] r;
    @(posedge CLK);
    CE <= 1'b0; // Raster holds during the load
    for (int i = 0; i < 1024; i++) begin
      r = $random(seed);
      @(posedge CLK);
      rom_init <= {10'(i), (rnd ? r[7:0] : 8'hfc), 1'b1};
    end
    @(posedge CLK);
    rom_init.valid <= 1'b0;
    CE <= 1'b1;
  endtask

  task automatic wait_vs_rise();
    @(posedge sync.vs);
  endtask

  // Scans from now up to the next VS rise
  task automatic scan_frame(input logic [15:0] colors);
    allowed   = colors;
    seen      = '0;
    frame_clk = 0;
    de_clk    = 0;
    de_lines  = 0;
    hs_clk    = 0;
    hs_lines  = 0;
    vs_clk    = 0;
    vbl_clk   = 0;
    scanning  = 1'b1;
    @(posedge sync.vs);
    scanning  = 1'b0;
  endtask

  task automatic end_test(input string name);
    if (errors == 0) begin
      passed++;
      $display("Test %s: ok", name);
    end else begin
      failed++;
      $display("Test %s: %0d errors", name, errors);
    end
    errors = 0;
  endtask

  //////////////////////////////
  // Test sequence

  initial begin
    seed     = 32'h97c8b653;
    CLK      = 1'b0;
    reset    = 1'b1;
    CE       = 1'b0;
    A        = '0;
    DB_I     = '0;
    WRB      = 1'b1;
    CSB      = 1'b1;
    rom_init = '0;
    scanning = 1'b0;
    errors   = 0;
    passed   = 0;
    failed   = 0;
    repeat (16) @(posedge CLK);
    reset <= 1'b0;
    load_rom(1'b0);
    fill_bgm(1'b1, 8'h00);

    wait_vs_rise();
    scan_frame(16'h0001); // Registers still zero from reset
    end_test("reset colour");
    check_sync("DE clock", de_clk, 208 * 232);
    check_sync("DE line", de_lines, 232);
    check_sync("HS clock", hs_clk, 20 * 263);
    check_sync("HS line", hs_lines, 263);
    check_sync("VS clock", vs_clk, 3 * 260);
    check_sync("VBL clock", vbl_clk, (263 - 232) * 260);
    check_sync("frame clock", frame_clk, 263 * 260);
    end_test("sync counts");

    // bm_clr_bg 2, lands in the shadow only
    write_regs(ctrl_regs_t'(32'h00_02_00_00));
    scan_frame(16'h0001);
    scan_frame(16'h0004);
    end_test("shadow registers");

    // Window 15 x 15, chars 5 on 9, bottom tile row uses bm_clr_bg 9
    write_regs(ctrl_regs_t'(32'h00_09_ff_59));
    wait_vs_rise();
    scan_frame(16'h0220);
    if (!(seen[5] && seen[9])) begin
      $display("Fail at %0t ns: colours 5 and 9 did not both appear", $time);
      errors++;
    end
    end_test("character mode");

    // bm_ena and bm_lores, bm_clr_bg 3, empty window
    write_regs(ctrl_regs_t'(32'h03_03_00_00));
    fill_bgm(1'b0, 8'h77);
    wait_vs_rise();
    scan_frame(16'h0080);
    fill_bgm(1'b0, 8'h00); // Transparent nibbles
    scan_frame(16'h0008);
    end_test("low resolution bitmap");

    // Both inversions, chars 12 on 6, random patterns
    load_rom(1'b1);
    write_regs(ctrl_regs_t'(32'hc0_03_00_c6));
    wait_vs_rise();
    scan_frame(16'h1040);
    end_test("window inversion");

    $display("Tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* vlog.f */
src/video_pkg.sv
src/bus_pkg.sv
src/video_timing.sv
src/cpu_port.sv
src/bgm_ram.sv
src/bg_render.sv
src/color_gen.sv
src/vdc_top.sv
testbench/tb_vdc.sv

/* Makefile */
# Verilator build and run of the background VDC testbench

SOURCES := $(shell grep -v '^+' vlog.f)

obj_dir/Vtb_vdc: vlog.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_vdc -f vlog.f

run: obj_dir/Vtb_vdc
	obj_dir/Vtb_vdc | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
